//--- src/fwd_pkg.sv
// types and helpers shared by the operand forwarding and stall logic
// modules import this in their bodies and use scoped names on their ports

package fwd_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int xlen      = 32;
    localparam int gpr_idx_w = 5;

    typedef logic [gpr_idx_w-1:0] gpr_idx_t;
    typedef logic [xlen-1:0]      xdata_t;

    // ========================================
    // writers in later stages
    // ========================================

    // gpr write request carried down the pipe
    typedef struct packed {
        gpr_idx_t rd;
        logic     write_gpr;
    } wr_port_t;

    // mem stage, alu result or load data depending on mem_to_reg
    typedef struct packed {
        wr_port_t wr;
        logic     mem_to_reg;
        xdata_t   alu_out;
        xdata_t   rdata;
    } mem_stage_t;

    // wb stage, one result bus for either operand
    typedef struct packed {
        wr_port_t wr;
        xdata_t   result;
    } wb_stage_t;

    // ========================================
    // hazard and bypass results
    // ========================================
    typedef struct packed {
        logic ex2;
        logic mem_alu;
        logic load_use;
        logic wb;
        logic id_wb;
    } src_hazard_t;

    typedef struct packed {
        logic   hit;
        xdata_t data;
    } fwd_t;

    // one hold per pipeline segment
    typedef struct packed {
        logic if_;
        logic id;
        logic ex1;
        logic ex2;
        logic mem;
        logic wb;
    } stall_t;

    // completion flags from fetch, execute and memory
    typedef struct packed {
        logic ifu_valid;
        logic exu_valid;
        logic mem_rvalid;
        logic mem_wdone;
    } done_t;

    // writer targets rs, x0 never counts
    function automatic logic gpr_match(input wr_port_t wr, input gpr_idx_t rs);
        return wr.write_gpr && (wr.rd == rs) && (wr.rd != '0);
    endfunction

endpackage

//--- src/hazard_detect.sv
// hazard classification of one source operand
// compares the id and ex1 indices against the ex2, mem and wb writers
`timescale 1ns/1ps

module hazard_detect (
    // operand index in decode
    input  fwd_pkg::gpr_idx_t    id_rs,
    // same operand one stage later, in ex1
    input  fwd_pkg::gpr_idx_t    ex_rs,
    input  fwd_pkg::wr_port_t    ex2_wr,
    input  fwd_pkg::mem_stage_t  mem_st,
    input  fwd_pkg::wb_stage_t   wb_st,
    output fwd_pkg::src_hazard_t haz
);

    import fwd_pkg::*;

    // ========================================
    // index comparators
    // ========================================

    // producer right behind ex1, not bypassable
    logic ex2_match;

    // mem writer, split below by mem_to_reg
    logic mem_match;

    // wb writer as seen from ex1 and from id
    logic wb_ex_match;
    logic wb_id_match;

    assign ex2_match   = gpr_match(ex2_wr, ex_rs);
    assign mem_match   = gpr_match(mem_st.wr, ex_rs);
    assign wb_ex_match = gpr_match(wb_st.wr, ex_rs);
    assign wb_id_match = gpr_match(wb_st.wr, id_rs);

    // ========================================
    // hazard classes
    // ========================================
    always_comb begin
        haz.ex2 = ex2_match;

        // alu result sits in mem
        haz.mem_alu = mem_match && !mem_st.mem_to_reg;

        // load in mem, read data is what gets bypassed
        haz.load_use = mem_match && mem_st.mem_to_reg;

        haz.wb = wb_ex_match;

        // id/wb case, goes straight into the id/ex register
        haz.id_wb = wb_id_match;
    end

endmodule

//--- src/pipeline_stall_ctrl.sv
// stall vector and ex1 flush for the whole pipeline
// a busy unit holds every stage, an ex2 hazard holds only the front
`timescale 1ns/1ps

module pipeline_stall_ctrl (
    input  fwd_pkg::done_t  done,
    // ex2 hazard flags of both operands
    input  logic            rs1_ex2_haz,
    input  logic            rs2_ex2_haz,
    output fwd_pkg::stall_t stall,
    output logic            flush_ex1
);

    // every stage has finished its current operation
    logic all_done;

    // hold for if, id and ex1
    logic front_hold;

    assign all_done = done.ifu_valid & done.exu_valid
                    & done.mem_rvalid & done.mem_wdone;

    // bubble into ex1 while the producer moves from ex2 to mem
    assign flush_ex1 = rs1_ex2_haz | rs2_ex2_haz;

    assign front_hold = ~all_done | flush_ex1;

    // ========================================
    // per stage holds
    // ========================================
    always_comb begin
        stall.if_ = front_hold;
        stall.id  = front_hold;
        stall.ex1 = front_hold;

        // back end keeps draining across an ex2 hazard
        stall.ex2 = ~all_done;
        stall.mem = ~all_done;
        stall.wb  = ~all_done;
    end

endmodule

//--- src/operand_forward_mux.sv
// bypass selection for one source operand
// exu_fwd feeds the ex1 operand input, seg_fwd feeds the id/ex register
`timescale 1ns/1ps

module operand_forward_mux (
    input  fwd_pkg::src_hazard_t haz,
    // ex1 is being turned into a bubble this cycle
    input  logic                 flush_ex1,
    input  fwd_pkg::mem_stage_t  mem_st,
    input  fwd_pkg::wb_stage_t   wb_st,
    output fwd_pkg::fwd_t        exu_fwd,
    output fwd_pkg::fwd_t        seg_fwd
);

    import fwd_pkg::*;

    // some later stage holds a bypassable value for ex1
    logic   ex_hit;

    // value picked by the mem-before-wb priority
    xdata_t prio_data;

    // id/wb bypass data
    xdata_t id_wb_data;

    assign ex_hit = haz.mem_alu | haz.load_use | haz.wb;

    // ========================================
    // priority value
    // ========================================
    always_comb begin
        if (haz.mem_alu) begin
            prio_data = mem_st.alu_out;
        end else if (haz.load_use) begin
            prio_data = mem_st.rdata;
        end else if (haz.wb) begin
            // older producer, only when mem has nothing newer
            prio_data = wb_st.result;
        end else begin
            prio_data = '0;
        end
    end

    assign id_wb_data = haz.id_wb ? wb_st.result : '0;

    // ========================================
    // ex1 operand bypass
    // ========================================
    always_comb begin
        exu_fwd.data = prio_data;

        // instruction in ex1 is flushed, its bypass is useless now
        exu_fwd.hit = ex_hit & ~flush_ex1;
    end

    // ========================================
    // id/ex segment bypass
    // ========================================
    always_comb begin
        if (flush_ex1 && ex_hit) begin
            // ex1 replays from id/ex, so capture the value there
            // before mem and wb move on
            seg_fwd.hit  = 1'b1;
            seg_fwd.data = prio_data;
        end else begin
            seg_fwd.hit  = haz.id_wb & ~flush_ex1;
            seg_fwd.data = id_wb_data;
        end
    end

endmodule

//--- src/forward_unit.sv
// operand forwarding and stall unit, top level
// two hazard detectors and bypass muxes, one per source, plus stall control
`timescale 1ns/1ps

module forward_unit (
    // ========================================
    // source indices
    // ========================================
    input  fwd_pkg::gpr_idx_t   id_rs1,
    input  fwd_pkg::gpr_idx_t   id_rs2,
    input  fwd_pkg::gpr_idx_t   ex_rs1,
    input  fwd_pkg::gpr_idx_t   ex_rs2,

    // ========================================
    // later stage writers
    // ========================================
    input  fwd_pkg::wr_port_t   ex2_wr,
    input  fwd_pkg::mem_stage_t mem_st,
    input  fwd_pkg::wb_stage_t  wb_st,

    // completion flags
    input  fwd_pkg::done_t      done,

    // ========================================
    // segment control
    // ========================================
    output fwd_pkg::stall_t     stall,
    output logic                flush_ex1,

    // ========================================
    // bypass results
    // ========================================
    output fwd_pkg::fwd_t       rs1_exu_fwd,
    output fwd_pkg::fwd_t       rs2_exu_fwd,
    output fwd_pkg::fwd_t       rs1_seg_fwd,
    output fwd_pkg::fwd_t       rs2_seg_fwd
);

    import fwd_pkg::*;

    src_hazard_t rs1_haz;
    src_hazard_t rs2_haz;

    // hazard classes per operand
    hazard_detect i_rs1_hazard_detect (
        .id_rs  (id_rs1),
        .ex_rs  (ex_rs1),
        .ex2_wr (ex2_wr),
        .mem_st (mem_st),
        .wb_st  (wb_st),
        .haz    (rs1_haz)
    );

    hazard_detect i_rs2_hazard_detect (
        .id_rs  (id_rs2),
        .ex_rs  (ex_rs2),
        .ex2_wr (ex2_wr),
        .mem_st (mem_st),
        .wb_st  (wb_st),
        .haz    (rs2_haz)
    );

    // either operand hitting ex2 flushes ex1 for both
    pipeline_stall_ctrl i_pipeline_stall_ctrl (
        .done        (done),
        .rs1_ex2_haz (rs1_haz.ex2),
        .rs2_ex2_haz (rs2_haz.ex2),
        .stall       (stall),
        .flush_ex1   (flush_ex1)
    );

    // bypass selection per operand
    operand_forward_mux i_rs1_forward_mux (
        .haz       (rs1_haz),
        .flush_ex1 (flush_ex1),
        .mem_st    (mem_st),
        .wb_st     (wb_st),
        .exu_fwd   (rs1_exu_fwd),
        .seg_fwd   (rs1_seg_fwd)
    );

    operand_forward_mux i_rs2_forward_mux (
        .haz       (rs2_haz),
        .flush_ex1 (flush_ex1),
        .mem_st    (mem_st),
        .wb_st     (wb_st),
        .exu_fwd   (rs2_exu_fwd),
        .seg_fwd   (rs2_seg_fwd)
    );

endmodule

//--- tests/forward_ref.svh
// expected forwarding and stall results, computed from the hazard rules
// include inside a module that imports fwd_pkg
`ifndef FORWARD_REF_SVH
`define FORWARD_REF_SVH

// writer hits rs only with write enable set and a nonzero destination
function automatic logic writer_targets(input wr_port_t wr, input gpr_idx_t rs);
    if (!wr.write_gpr) begin
        return 1'b0;
    end
    if (wr.rd == 5'd0) begin
        return 1'b0;
    end
    return wr.rd == rs;
endfunction

function automatic src_hazard_t classify_operand(input gpr_idx_t id_rs, input gpr_idx_t ex_rs,
                                                 input wr_port_t ex2_w, input mem_stage_t mem_w,
                                                 input wb_stage_t wb_w);
    src_hazard_t h;
    h.ex2      = writer_targets(ex2_w, ex_rs);
    h.mem_alu  = writer_targets(mem_w.wr, ex_rs) && !mem_w.mem_to_reg;
    h.load_use = writer_targets(mem_w.wr, ex_rs) && mem_w.mem_to_reg;
    h.wb       = writer_targets(wb_w.wr, ex_rs);
    h.id_wb    = writer_targets(wb_w.wr, id_rs);
    return h;
endfunction

// front stages also hold on an ex2 hazard
function automatic stall_t predicted_stall(input done_t d, input logic flush);
    stall_t s;
    logic   busy;
    busy  = !(d.ifu_valid && d.exu_valid && d.mem_rvalid && d.mem_wdone);
    s.if_ = busy || flush;
    s.id  = busy || flush;
    s.ex1 = busy || flush;
    s.ex2 = busy;
    s.mem = busy;
    s.wb  = busy;
    return s;
endfunction

// mem alu result first, then load data, then wb
function automatic xdata_t priority_value(input src_hazard_t h, input mem_stage_t mem_w,
                                          input wb_stage_t wb_w);
    if (h.mem_alu) return mem_w.alu_out;
    if (h.load_use) return mem_w.rdata;
    if (h.wb) return wb_w.result;
    return 32'h0;
endfunction

function automatic fwd_t exu_bypass(input src_hazard_t h, input logic flush,
                                    input mem_stage_t mem_w, input wb_stage_t wb_w);
    fwd_t f;
    f.hit  = (h.mem_alu || h.load_use || h.wb) && !flush;
    f.data = priority_value(h, mem_w, wb_w);
    return f;
endfunction

function automatic fwd_t segment_bypass(input src_hazard_t h, input logic flush,
                                        input mem_stage_t mem_w, input wb_stage_t wb_w);
    fwd_t f;
    if (flush && (h.mem_alu || h.load_use || h.wb)) begin
        f.hit  = 1'b1;
        f.data = priority_value(h, mem_w, wb_w);
    end else begin
        f.hit  = h.id_wb && !flush;
        f.data = h.id_wb ? wb_w.result : 32'h0;
    end
    return f;
endfunction

`endif

//--- tests/tb_forward_unit.sv
// testbench for the forwarding and stall unit
// directed hazard cases and lfsr vectors, outputs checked against reference functions
`timescale 1ns/1ps

module tb_forward_unit;

    import fwd_pkg::*;

    `include "forward_ref.svh"

    localparam int reset_cycles = 5;
    localparam int n_directed   = 40;
    localparam int n_random     = 2000;
    // stimulus length plus half again as margin
    localparam int run_cycles   = reset_cycles + n_directed + n_random;
    localparam int max_cycles   = run_cycles + run_cycles / 2;

    localparam xdata_t alu_val    = 32'h1111_a1a1;
    localparam xdata_t rdata_val  = 32'h2222_d2d2;
    localparam xdata_t result_val = 32'h3333_b3b3;
    localparam done_t  done_all   = 4'b1111;

    logic        clk;
    logic        reset;
    gpr_idx_t    id_rs1, id_rs2, ex_rs1, ex_rs2;
    wr_port_t    ex2_wr;
    mem_stage_t  mem_st;
    wb_stage_t   wb_st;
    done_t       done;
    stall_t      stall;
    logic        flush_ex1;
    fwd_t        rs1_exu_fwd, rs2_exu_fwd, rs1_seg_fwd, rs2_seg_fwd;

    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state = 32'hb032;

    forward_unit i_forward_unit (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex2_wr      (ex2_wr),
        .mem_st      (mem_st),
        .wb_st       (wb_st),
        .done        (done),
        .stall       (stall),
        .flush_ex1   (flush_ex1),
        .rs1_exu_fwd (rs1_exu_fwd),
        .rs2_exu_fwd (rs2_exu_fwd),
        .rs1_seg_fwd (rs1_seg_fwd),
        .rs2_seg_fwd (rs2_seg_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================
    // stimulus helpers
    // ========================================

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int width, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic wr_port_t wr_port(input gpr_idx_t rd, input logic we);
        return '{rd: rd, write_gpr: we};
    endfunction

    function automatic mem_stage_t mem_writer(input gpr_idx_t rd, input logic we, input logic load);
        return '{wr: wr_port(rd, we), mem_to_reg: load, alu_out: alu_val, rdata: rdata_val};
    endfunction

    function automatic wb_stage_t wb_writer(input gpr_idx_t rd, input logic we);
        return '{wr: wr_port(rd, we), result: result_val};
    endfunction

    task automatic apply_vector(input gpr_idx_t i1, input gpr_idx_t i2, input gpr_idx_t e1,
                                input gpr_idx_t e2, input wr_port_t w2, input mem_stage_t m,
                                input wb_stage_t w, input done_t d);
        @(posedge clk);
        id_rs1 <= i1;
        id_rs2 <= i2;
        ex_rs1 <= e1;
        ex_rs2 <= e2;
        ex2_wr <= w2;
        mem_st <= m;
        wb_st  <= w;
        done   <= d;
    endtask

    task automatic compare_field(input string name, input logic [32:0] act,
                                 input logic [32:0] exp);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // ========================================
    // directed and random sequences
    // ========================================
    task automatic directed_cases();
        wr_port_t   no_ex2;
        mem_stage_t no_mem;
        wb_stage_t  no_wb;
        no_ex2 = wr_port(5'd0, 1'b0);
        no_mem = mem_writer(5'd0, 1'b0, 1'b0);
        no_wb  = wb_writer(5'd0, 1'b0);
        // idle
        apply_vector(5'd1, 5'd2, 5'd1, 5'd2, no_ex2, no_mem, no_wb, done_all);
        apply_vector(5'd0, 5'd0, 5'd0, 5'd0, no_ex2, no_mem, no_wb, done_all);
        // one done flag low at a time, then all
        for (int i = 0; i < 4; i++) begin
            apply_vector(5'd1, 5'd2, 5'd1, 5'd2, no_ex2, no_mem, no_wb, done_all ^ (4'b1 << i));
        end
        apply_vector(5'd1, 5'd2, 5'd1, 5'd2, no_ex2, no_mem, no_wb, 4'b0000);
        // ex2 hazards, bypasses move to the segment side
        apply_vector(5'd0, 5'd0, 5'd1, 5'd2, wr_port(5'd1, 1'b1), no_mem, no_wb, done_all);
        apply_vector(5'd0, 5'd0, 5'd1, 5'd2, wr_port(5'd2, 1'b1),
                     mem_writer(5'd1, 1'b1, 1'b0), no_wb, done_all);
        apply_vector(5'd0, 5'd0, 5'd1, 5'd2, wr_port(5'd1, 1'b1), no_mem,
                     wb_writer(5'd2, 1'b1), done_all);
        apply_vector(5'd0, 5'd0, 5'd1, 5'd1, wr_port(5'd1, 1'b1),
                     mem_writer(5'd1, 1'b1, 1'b1), no_wb, done_all);
        apply_vector(5'd3, 5'd0, 5'd1, 5'd2, wr_port(5'd1, 1'b1), no_mem,
                     wb_writer(5'd3, 1'b1), done_all);
        apply_vector(5'd0, 5'd0, 5'd1, 5'd2, wr_port(5'd1, 1'b1), no_mem, no_wb, 4'b1011);
        // mem over wb, load data, id/wb
        apply_vector(5'd0, 5'd0, 5'd3, 5'd0, no_ex2, mem_writer(5'd3, 1'b1, 1'b0),
                     wb_writer(5'd3, 1'b1), done_all);
        apply_vector(5'd0, 5'd0, 5'd0, 5'd3, no_ex2, mem_writer(5'd3, 1'b1, 1'b1),
                     wb_writer(5'd3, 1'b1), done_all);
        apply_vector(5'd0, 5'd0, 5'd3, 5'd3, no_ex2, no_mem, wb_writer(5'd3, 1'b1), done_all);
        apply_vector(5'd3, 5'd0, 5'd1, 5'd2, no_ex2, no_mem, wb_writer(5'd3, 1'b1), done_all);
        apply_vector(5'd1, 5'd3, 5'd0, 5'd3, no_ex2, no_mem, wb_writer(5'd3, 1'b1), done_all);
        apply_vector(5'd0, 5'd0, 5'd3, 5'd3, no_ex2, mem_writer(5'd3, 1'b0, 1'b0),
                     no_wb, done_all);
        // x0 writers everywhere
        apply_vector(5'd0, 5'd0, 5'd0, 5'd0, wr_port(5'd0, 1'b1), mem_writer(5'd0, 1'b1, 1'b0),
                     wb_writer(5'd0, 1'b1), done_all);
        apply_vector(5'd0, 5'd0, 5'd0, 5'd0, wr_port(5'd0, 1'b1), mem_writer(5'd0, 1'b1, 1'b1),
                     wb_writer(5'd0, 1'b1), done_all);
    endtask

    task automatic random_vectors(input int count);
        logic [31:0] r;
        gpr_idx_t    idx[7];
        logic        we[3];
        logic        load;
        mem_stage_t  m;
        wb_stage_t   w;
        done_t       d;
        for (int n = 0; n < count; n++) begin
            // indices 0..3 so matches come often
            for (int k = 0; k < 7; k++) begin
                draw_bits(2, r);
                idx[k] = r[4:0];
            end
            for (int k = 0; k < 3; k++) begin
                draw_bits(1, r);
                we[k] = r[0];
            end
            draw_bits(1, r);
            load = r[0];
            m = mem_writer(idx[5], we[1], load);
            draw_bits(32, r);
            m.alu_out = r;
            draw_bits(32, r);
            m.rdata = r;
            w = wb_writer(idx[6], we[2]);
            draw_bits(32, r);
            w.result = r;
            // each flag set three times in four
            for (int k = 0; k < 4; k++) begin
                draw_bits(2, r);
                d[k] = |r[1:0];
            end
            apply_vector(idx[0], idx[1], idx[2], idx[3], wr_port(idx[4], we[0]), m, w, d);
        end
    endtask

    // ========================================
    // comparison on the falling edge
    // ========================================
    always @(negedge clk) begin : compare_outputs
        src_hazard_t h1;
        src_hazard_t h2;
        logic        exp_flush;
        if (!reset) begin
            h1 = classify_operand(id_rs1, ex_rs1, ex2_wr, mem_st, wb_st);
            h2 = classify_operand(id_rs2, ex_rs2, ex2_wr, mem_st, wb_st);
            exp_flush = h1.ex2 || h2.ex2;
            compare_field("flush_ex1", flush_ex1, exp_flush);
            compare_field("stall", stall, predicted_stall(done, exp_flush));
            compare_field("rs1_exu_fwd", rs1_exu_fwd, exu_bypass(h1, exp_flush, mem_st, wb_st));
            compare_field("rs2_exu_fwd", rs2_exu_fwd, exu_bypass(h2, exp_flush, mem_st, wb_st));
            compare_field("rs1_seg_fwd", rs1_seg_fwd,
                          segment_bypass(h1, exp_flush, mem_st, wb_st));
            compare_field("rs2_seg_fwd", rs2_seg_fwd,
                          segment_bypass(h2, exp_flush, mem_st, wb_st));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", max_cycles);
            $display("checks %0d errors %0d", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reset  = 1'b1;
        id_rs1 <= '0;
        id_rs2 <= '0;
        ex_rs1 <= '0;
        ex_rs2 <= '0;
        ex2_wr <= '0;
        mem_st <= '0;
        wb_st  <= '0;
        done   <= done_all;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        directed_cases();
        random_vectors(n_random);
        // let the last vector be compared
        @(posedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- forward_unit.f
+incdir+tests
src/fwd_pkg.sv
src/hazard_detect.sv
src/pipeline_stall_ctrl.sv
src/operand_forward_mux.sv
src/forward_unit.sv
tests/tb_forward_unit.sv
